// ==== Bender.yml ====
package:
  name: usb_cam_stream

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/pixel_pkg.sv
      - hw/usb_pkg.sv
      - hw/byte_fifo_if.sv
      - hw/byte_fifo.sv
      - hw/bulk_in_gate.sv
      - hw/heartbeat_div.sv
      - hw/usb_cam_stream.sv

  - target: test
    include_dirs:
      - include
    files:
      - dv/tb_usb_cam_stream.sv

// ==== dv/tb_usb_cam_stream.sv ====
`timescale 1ns/1ps
`include "stream_settings.svh"

module tb_usb_cam_stream;

  localparam int DEPTH  = `STREAM_FIFO_DEPTH;
  localparam int PKT    = `STREAM_PKT_LEN;
  localparam int HB     = 10;                     // Short heartbeat for simulation
  localparam int RST_CY = 4;
  // Cycle budget per test with reset included
  localparam int BUDGET = 6 * RST_CY + 10 + 1000 + 3000 + 150 + 2700 + 60;

  logic        ulpi_clk;
  logic        I_rst_n;
  logic        pixel_valid_i;
  logic [15:0] pixel_data_i;
  logic        tx_act_i;
  logic        tx_pop_i;
  logic [7:0]  tx_data_o;
  logic        tx_cork_o;
  logic [`STREAM_LEN_W-1:0]   tx_len_o;
  logic [`STREAM_LEVEL_W-1:0] fill_level_o;
  logic        pixel_drop_o;
  logic        heartbeat_o;

  integer      seed = 75;
  int          errors = 0;
  int          err_start = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;
  logic [7:0]  model_q [$];                       // Expected byte stream
  logic        ready_m;                           // Expected latched ready
  logic [`STREAM_LEN_W-1:0] len_m;                // Expected latched length
  logic        drop_m;                            // Expected drop pulse

  usb_cam_stream #(
    .HB_HALF (HB)
  ) u_usb_cam_stream (
    .ulpi_clk      (ulpi_clk),
    .I_rst_n       (I_rst_n),
    .pixel_valid_i (pixel_valid_i),
    .pixel_data_i  (pixel_data_i),
    .tx_act_i      (tx_act_i),
    .tx_pop_i      (tx_pop_i),
    .tx_data_o     (tx_data_o),
    .tx_cork_o     (tx_cork_o),
    .tx_len_o      (tx_len_o),
    .fill_level_o  (fill_level_o),
    .pixel_drop_o  (pixel_drop_o),
    .heartbeat_o   (heartbeat_o)
  );

  initial begin
    ulpi_clk = 1'b0;
    forever #2 ulpi_clk = ~ulpi_clk;              // 4 ns period
  end

  // Ends a run that stops making progress
  initial begin
    #(BUDGET * 4 + 1000);
    $display("Watchdog: run timed out before all tests finished");
    $display("test failed");
    $finish;
  end

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  // ==================================================
  // Reset and per cycle model
  // ==================================================

  task automatic apply_reset();
    pixel_valid_i = 1'b0;
    pixel_data_i  = '0;
    tx_act_i      = 1'b0;
    tx_pop_i      = 1'b0;
    I_rst_n       = 1'b0;
    repeat (RST_CY) begin
      @(posedge ulpi_clk);
      #1;
      check_val("tx_cork_o", tx_cork_o, 1);      // Held values during reset
      check_val("tx_len_o", tx_len_o, 0);
      check_val("fill_level_o", fill_level_o, 0);
      check_val("pixel_drop_o", pixel_drop_o, 0);
      check_val("heartbeat_o", heartbeat_o, 0);
    end
    I_rst_n = 1'b1;
    model_q.delete();
    ready_m = 1'b0;
    len_m   = '0;
    drop_m  = 1'b0;
  endtask

  // Drives one cycle at edge plus 1 ns and checks after the next edge
  task automatic step(input logic valid, input logic [15:0] data, input logic act,
                      input logic pop);
    int         lvl;
    logic       acc;
    logic       pop_ok;
    pixel_valid_i = valid;
    pixel_data_i  = data;
    tx_act_i      = act;
    tx_pop_i      = pop;
    lvl    = model_q.size();
    acc    = valid && (lvl <= DEPTH - 2);         // Room for both bytes
    pop_ok = pop && (lvl >= PKT);                 // Pop needs a full packet queued
    if (pop_ok) begin
      check_val("tx_data_o", tx_data_o, model_q[0]);
      void'(model_q.pop_front());
    end
    if (acc) begin
      model_q.push_back(data[7:0]);               // Low byte leaves first
      model_q.push_back(data[15:8]);
    end
    if (!act) begin
      ready_m = (lvl >= PKT);                     // Latched only while idle
      len_m   = PKT;
    end
    drop_m = valid && !acc;
    @(posedge ulpi_clk);
    #1;
    check_val("fill_level_o", fill_level_o, model_q.size());
    check_val("pixel_drop_o", pixel_drop_o, drop_m);
    check_val("tx_cork_o", tx_cork_o, !ready_m);
    check_val("tx_len_o", tx_len_o, len_m);
    if (model_q.size() != 0) begin
      check_val("tx_data_o", tx_data_o, model_q[0]);  // Head valid when not empty
    end
  endtask

  task automatic finish_test(input string name);
    if (errors == err_start) begin
      tests_ok++;
    end else begin
      tests_bad++;
    end
    $display("[%s] finished with %0d mismatches", name, errors - err_start);
    err_start = errors;
  endtask

  // ==================================================
  // Test sequence
  // ==================================================

  initial begin
    int n;
    int last;
    int toggles;
    logic hb_prev;
    pixel_valid_i = 1'b0;
    pixel_data_i  = '0;
    tx_act_i      = 1'b0;
    tx_pop_i      = 1'b0;
    I_rst_n       = 1'b0;

    apply_reset();
    repeat (10) step(1'b0, 16'h0, 1'b0, 1'b0);   // Idle after release
    finish_test("reset values");

    apply_reset();
    repeat (8) step($random(seed) & 1, $random(seed), 1'b1, 1'b0);  // Busy so length holds at 0
    n = 0;
    while (model_q.size() < PKT + 8 && n < 800) begin
      step($random(seed) & 1, $random(seed), 1'b0, 1'b0);
      n++;
    end
    check_val("tx_len_o", tx_len_o, PKT);
    repeat (20) step(1'b0, 16'h0, 1'b1, 1'b1);   // Busy while level falls below a packet
    step(1'b0, 16'h0, 1'b0, 1'b0);               // One idle cycle raises cork
    repeat (20) step(1'b1, $random(seed), 1'b1, 1'b0);  // Busy while level climbs again
    finish_test("cork and length");

    apply_reset();
    repeat (3000) begin
      step(($random(seed) & 7) < 3, $random(seed), $random(seed) & 1, ($random(seed) & 7) != 0);
    end
    finish_test("byte stream");

    apply_reset();
    repeat (100) step(1'b1, $random(seed), 1'b0, 1'b0);
    repeat (50) step(1'b0, 16'h0, $random(seed) & 1, 1'b1);  // 200 bytes so pops are ignored
    check_val("fill_level_o", fill_level_o, 200);
    finish_test("pop below packet");

    apply_reset();
    repeat (1100) step(1'b1, $random(seed), 1'b0, 1'b0);
    check_val("fill_level_o", fill_level_o, DEPTH);
    repeat (1600) step(1'b0, 16'h0, 1'b1, 1'b1);  // Drain down to one byte short
    finish_test("overflow drop");

    apply_reset();
    last    = 0;
    toggles = 0;
    hb_prev = heartbeat_o;
    for (int i = 1; i <= 60; i++) begin
      step(1'b0, 16'h0, 1'b0, 1'b0);
      if (heartbeat_o !== hb_prev) begin
        check_val("heartbeat_gap", i - last, HB);
        last = i;
        toggles++;
      end
      hb_prev = heartbeat_o;
    end
    check_val("heartbeat_toggles", toggles, 60 / HB);
    finish_test("heartbeat");

    $display("Tests: %0d clean, %0d with mismatches, %0d mismatches total",
             tests_ok, tests_bad, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== hw/bulk_in_gate.sv ====
`timescale 1ns/1ps
`include "stream_settings.svh"

module bulk_in_gate (
  input  logic              ulpi_clk,
  input  logic              I_rst_n,
  input  logic              tx_act_i,   // Controller busy with a packet
  input  logic              tx_pop_i,   // Controller takes one byte
  output logic              tx_cork_o,  // Hold off the controller
  output usb_pkg::pkt_len_t tx_len_o,   // Length of the offered packet
  byte_fifo_if.gate         fifo        // FIFO status and pop
);

  // ==================================================
  // Ready decision while the controller is idle
  // ==================================================

  logic              ready_q;           // Full packet queued at last idle cycle
  usb_pkg::pkt_len_t len_q;             // Length latched with ready
  logic              pkt_avail;         // At least one packet queued now

  assign pkt_avail = (fifo.level >= usb_pkg::PKT_THRESHOLD);

  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      ready_q <= 1'b0;                  // Corked out of reset
      len_q   <= '0;
    end else if (!tx_act_i) begin
      ready_q <= pkt_avail;             // Sampled only when idle
      len_q   <= usb_pkg::PKT_LEN;
    end
  end

  // Frozen during a transfer
  assign tx_cork_o = ~ready_q;
  assign tx_len_o  = len_q;

  // ==================================================
  // Pop conversion
  // ==================================================

  // Pops below one packet are ignored and the head stays
  assign fifo.rd_en = tx_pop_i && pkt_avail && !fifo.empty;

endmodule

// ==== hw/byte_fifo.sv ====
`timescale 1ns/1ps
`include "stream_settings.svh"

module byte_fifo #(
  parameter int DEPTH = `STREAM_FIFO_DEPTH  // Byte capacity as a power of two
) (
  input  logic              ulpi_clk,
  input  logic              I_rst_n,
  input  logic              pixel_valid_i,  // Pixel strobe
  input  pixel_pkg::pixel_t pixel_i,        // Pixel word
  output logic              pixel_drop_o,   // Pulse after a refused pixel
  byte_fifo_if.fifo         rd              // Read side toward the gate
);

  localparam int ADDR_W = $clog2(DEPTH);

  // ==================================================
  // Storage and pointers
  // ==================================================

  pixel_pkg::byte_t          mem [DEPTH];   // Circular byte store
  logic [ADDR_W-1:0]         wr_ptr;        // Next free slot
  logic [ADDR_W-1:0]         wr_ptr_hi;     // Slot for the high byte
  logic [ADDR_W-1:0]         rd_ptr;        // Oldest byte
  usb_pkg::level_t           level_q;       // Bytes queued
  pixel_pkg::pixel_bytes_t   pix_bytes;     // Pixel split in lanes
  logic                      wr_ok;         // Pixel accepted this cycle

  assign pix_bytes = pixel_i;               // Same width, lane view
  assign wr_ptr_hi = wr_ptr + 1'b1;         // Wraps with the pointer width

  // Almost full rule: room for both bytes
  assign wr_ok = pixel_valid_i && (level_q <= usb_pkg::level_t'(DEPTH - 2));

  // Two bytes per accepted pixel, low byte first
  always_ff @(posedge ulpi_clk) begin
    if (wr_ok) begin
      mem[wr_ptr]    <= pix_bytes.lo;       // Leaves first
      mem[wr_ptr_hi] <= pix_bytes.hi;       // Leaves second
    end
  end

  // ==================================================
  // Pointer and level bookkeeping
  // ==================================================

  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      level_q      <= '0;
      pixel_drop_o <= 1'b0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + ADDR_W'(pixel_pkg::BYTES_PER_PIXEL);  // Skip both slots
      end
      if (rd.rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;            // Gate guarantees not empty
      end
      unique case ({wr_ok, rd.rd_en})
        2'b10:   level_q <= level_q + usb_pkg::level_t'(2);  // Pixel only
        2'b01:   level_q <= level_q - usb_pkg::level_t'(1);  // Pop only
        2'b11:   level_q <= level_q + usb_pkg::level_t'(1);  // Net plus one
        default: level_q <= level_q;                         // Idle
      endcase
      pixel_drop_o <= pixel_valid_i && !wr_ok;  // Whole pixel lost
    end
  end

  // Read side outputs
  assign rd.head  = mem[rd_ptr];            // No read latency
  assign rd.level = level_q;
  assign rd.empty = (level_q == '0);

endmodule

// ==== hw/byte_fifo_if.sv ====
`timescale 1ns/1ps

// Read side of the stream FIFO as seen by the packet gate
interface byte_fifo_if ();

  logic               rd_en;   // Pop head at clock edge
  pixel_pkg::byte_t   head;    // Oldest byte, valid while not empty
  usb_pkg::level_t    level;   // Bytes queued
  logic               empty;   // No byte queued

  // FIFO owns data and status
  modport fifo (
    input  rd_en,
    output head,
    output level,
    output empty
  );

  // Gate only sees status and issues pops
  modport gate (
    output rd_en,
    input  level,
    input  empty
  );

endinterface

// ==== hw/heartbeat_div.sv ====
`timescale 1ns/1ps
`include "stream_settings.svh"

module heartbeat_div #(
  parameter int HALF_PERIOD = `STREAM_HB_HALF  // Cycles between toggles
) (
  input  logic ulpi_clk,
  input  logic I_rst_n,
  output logic heartbeat_o                     // Debug square wave
);

  localparam int CNT_W = (HALF_PERIOD > 1) ? $clog2(HALF_PERIOD) : 1;

  logic [CNT_W-1:0] cnt_q;                     // Cycles in the current half
  logic             wrap;                      // Last cycle of the half

  assign wrap = (cnt_q == CNT_W'(HALF_PERIOD - 1));

  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      cnt_q       <= '0;
      heartbeat_o <= 1'b0;
    end else if (wrap) begin
      cnt_q       <= '0;                       // Start next half
      heartbeat_o <= ~heartbeat_o;             // Toggle on wrap
    end else begin
      cnt_q       <= cnt_q + 1'b1;
    end
  end

endmodule

// ==== hw/pixel_pkg.sv ====
// ==================================================
// Capture side types
// ==================================================

package pixel_pkg;

  // Pixel as delivered by the camera path
  typedef logic [15:0] pixel_t;   // RGB565 word

  // Storage unit of the stream FIFO
  typedef logic [7:0] byte_t;     // One USB byte

  // Pixels split into low byte then high byte
  localparam int BYTES_PER_PIXEL = 2;

  // Byte lanes within a pixel
  typedef struct packed {
    byte_t hi;                    // Sent second
    byte_t lo;                    // Sent first
  } pixel_bytes_t;

endpackage

// ==== hw/usb_cam_stream.sv ====
`timescale 1ns/1ps
`include "stream_settings.svh"

module usb_cam_stream #(
  parameter int HB_HALF = `STREAM_HB_HALF         // Heartbeat half period
) (
  input  logic                        ulpi_clk,       // 60 MHz from the PHY
  input  logic                        I_rst_n,
  // Pixel ingest
  input  logic                        pixel_valid_i,
  input  logic [15:0]                 pixel_data_i,
  // Bulk IN toward the USB controller
  input  logic                        tx_act_i,       // Packet in progress
  input  logic                        tx_pop_i,       // Byte taken
  output logic [7:0]                  tx_data_o,      // Presented before pop
  output logic                        tx_cork_o,      // Hold off
  output logic [`STREAM_LEN_W-1:0]    tx_len_o,       // Packet length
  // Status and debug
  output logic [`STREAM_LEVEL_W-1:0]  fill_level_o,   // Bytes queued
  output logic                        pixel_drop_o,   // Pixel refused
  output logic                        heartbeat_o     // Debug toggle
);

  // ==================================================
  // FIFO to gate link
  // ==================================================

  byte_fifo_if u_fifo_rd ();

  // Pixels into bytes
  byte_fifo #(
    .DEPTH (`STREAM_FIFO_DEPTH)
  ) u_byte_fifo (
    .ulpi_clk      (ulpi_clk),
    .I_rst_n       (I_rst_n),
    .pixel_valid_i (pixel_valid_i),
    .pixel_i       (pixel_data_i),
    .pixel_drop_o  (pixel_drop_o),
    .rd            (u_fifo_rd.fifo)
  );

  // Packet gating and pops
  bulk_in_gate u_bulk_in_gate (
    .ulpi_clk  (ulpi_clk),
    .I_rst_n   (I_rst_n),
    .tx_act_i  (tx_act_i),
    .tx_pop_i  (tx_pop_i),
    .tx_cork_o (tx_cork_o),
    .tx_len_o  (tx_len_o),
    .fifo      (u_fifo_rd.gate)
  );

  // Head and level go straight out
  assign tx_data_o    = u_fifo_rd.head;
  assign fill_level_o = u_fifo_rd.level;

  // ==================================================
  // Debug heartbeat
  // ==================================================

  heartbeat_div #(
    .HALF_PERIOD (HB_HALF)
  ) u_heartbeat_div (
    .ulpi_clk    (ulpi_clk),
    .I_rst_n     (I_rst_n),
    .heartbeat_o (heartbeat_o)
  );

endmodule

// ==== hw/usb_pkg.sv ====
`include "stream_settings.svh"

// ==================================================
// USB side types
// ==================================================

package usb_pkg;

  // Bytes queued in the stream FIFO
  typedef logic [`STREAM_LEVEL_W-1:0] level_t;

  // Packet length handed to the controller
  typedef logic [`STREAM_LEN_W-1:0] pkt_len_t;

  // Fill level needed before a packet is offered
  localparam level_t PKT_THRESHOLD = level_t'(`STREAM_PKT_LEN);

  // Fixed length reported with each packet
  localparam pkt_len_t PKT_LEN = pkt_len_t'(`STREAM_PKT_LEN);

endpackage

// ==== include/stream_settings.svh ====
`ifndef STREAM_SETTINGS_SVH
`define STREAM_SETTINGS_SVH

// ==================================================
// Stream sizing for the pixel to USB bulk path
// ==================================================

`define STREAM_FIFO_DEPTH 2048      // Byte capacity as a power of two
`define STREAM_PKT_LEN    512       // High speed bulk packet size
`define STREAM_LEVEL_W    12        // Holds 0 up to full depth
`define STREAM_LEN_W      12        // Length field of the controller

// One second square wave at 60 MHz
`define STREAM_HB_HALF    30000000

`endif

// ==== usb_cam_stream.f ====
+incdir+include
hw/pixel_pkg.sv
hw/usb_pkg.sv
hw/byte_fifo_if.sv
hw/byte_fifo.sv
hw/bulk_in_gate.sv
hw/heartbeat_div.sv
hw/usb_cam_stream.sv
dv/tb_usb_cam_stream.sv
